// File: program.hex
// one 32-bit word per line in hex, program from address 0
// data region starts at byte 0x100 (word 40 hex)
24010100
8c220000
8c230004
// r-type results
00432021
ac240008
00432023
ac24000c
00432024
ac240010
00432025
ac240014
00432026
ac240018
00432027
ac24001c
0043202a
ac240020
0043202b
ac240024
00032100
ac240028
00022202
ac24002c
// immediate forms
2464fff0
ac240030
2844ffff
ac240034
30448f0f
ac240038
34648000
ac24003c
3844ffff
ac240040
3c04a5c3
ac240044
// store and load round trip, register 0
ac220048
8c250048
ac25004c
24001234
ac200050
// branches, jumps and link
10430001
ac230054
10420001
ac230058
14430001
ac23005c
14630001
ac220060
0c000034
ac3f0064
08000038
ac230068
ac22006c
03e00008
ac230070
ac230074
ffffffff
ac230078
@40
fffffff0
00000025
c0de0108
c0de010c
c0de0110
c0de0114
c0de0118
c0de011c
c0de0120
c0de0124
c0de0128
c0de012c
c0de0130
c0de0134
c0de0138
c0de013c
c0de0140
c0de0144
c0de0148
c0de014c
c0de0150
c0de0154
c0de0158
c0de015c
c0de0160
c0de0164
c0de0168
c0de016c
c0de0170
c0de0174
c0de0178
c0de017c

// File: verilog.f
cpu_types_pkg.sv
control_unit.sv
alu.sv
register_file.sv
program_counter.sv
request_unit.sv
datapath.sv
memory_control.sv
ram.sv
cpu_top.sv
tb_cpu_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, pass only if the log holds the pass message
cd "$(dirname "$0")" &&
verilator --binary -f verilog.f --top-module tb_cpu_top -o sim_cpu &&
./obj_dir/sim_cpu | tee sim.log &&
grep -q "Result: PASSED" sim.log || exit 1

// File: tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

  localparam cpu_types_pkg::word_t PC_INIT   = 32'h0000_0000;
  localparam int                   RAM_LAT   = 2;
  localparam int                   MEM_WORDS = 1024;
  localparam int                   IDX_W     = $clog2(MEM_WORDS);

  // data region holding operands and result slots
  localparam cpu_types_pkg::word_t DATA_BASE  = 32'h0000_0100;
  localparam int                   DATA_WORDS = 32;

  localparam int REF_LIMIT    = 1000;
  localparam int HALT_TIMEOUT = 5000;

  logic                 CLK = 1'b0;
  logic                 rst_n;
  logic                 halt;
  cpu_types_pkg::word_t dump_addr;
  cpu_types_pkg::word_t dump_data;

  // expected memory image and register state of the ISA model
  cpu_types_pkg::word_t exp_mem [MEM_WORDS];
  cpu_types_pkg::word_t ref_regs [32];

  int errors = 0;
  int checks = 0;

  cpu_top #(
    .PC_INIT   (PC_INIT),
    .RAM_LAT   (RAM_LAT),
    .MEM_WORDS (MEM_WORDS)
  ) u_dut (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .halt      (halt),
    .dump_addr (dump_addr),
    .dump_data (dump_data)
  );

  always #4 CLK = ~CLK;

  function automatic logic [IDX_W-1:0] word_index(input cpu_types_pkg::word_t addr);
    return addr[IDX_W+1:2];
  endfunction

  // runs the program on the ISA rules until the halt word
  // returns the number of instructions retired, or -1 past the limit
  function automatic int run_reference();
    cpu_types_pkg::word_t ir;
    cpu_types_pkg::word_t pc;
    cpu_types_pkg::word_t npc;
    cpu_types_pkg::word_t a;
    cpu_types_pkg::word_t b;
    cpu_types_pkg::word_t simm;
    cpu_types_pkg::word_t zimm;
    cpu_types_pkg::word_t wval;
    logic [4:0]           wreg;
    logic                 wr;
    int                   n;
    exp_mem = '{default: '0};
    $readmemh("program.hex", exp_mem);
    ref_regs = '{default: '0};
    pc = PC_INIT;
    for (n = 0; n < REF_LIMIT; n++) begin
      ir = exp_mem[word_index(pc)];
      if (ir == cpu_types_pkg::HALT_WORD) begin
        return n;
      end
      a    = ref_regs[ir[25:21]];
      b    = ref_regs[ir[20:16]];
      simm = {{16{ir[15]}}, ir[15:0]};
      zimm = {16'h0000, ir[15:0]};
      npc  = pc + 32'd4;
      wr   = 1'b0;
      wreg = ir[20:16];
      wval = '0;
      case (ir[31:26])
        cpu_types_pkg::RTYPE: begin
          wr   = 1'b1;
          wreg = ir[15:11];
          case (ir[5:0])
            cpu_types_pkg::SLL:  wval = b << ir[10:6];
            cpu_types_pkg::SRL:  wval = b >> ir[10:6];
            cpu_types_pkg::ADDU: wval = a + b;
            cpu_types_pkg::SUBU: wval = a - b;
            cpu_types_pkg::AND:  wval = a & b;
            cpu_types_pkg::OR:   wval = a | b;
            cpu_types_pkg::XOR:  wval = a ^ b;
            cpu_types_pkg::NOR:  wval = ~(a | b);
            cpu_types_pkg::SLT:  wval = {31'd0, $signed(a) < $signed(b)};
            cpu_types_pkg::SLTU: wval = {31'd0, a < b};
            cpu_types_pkg::JR: begin
              wr  = 1'b0;
              npc = a;
            end
            default: wr = 1'b0;
          endcase
        end
        cpu_types_pkg::ADDIU: begin
          wr   = 1'b1;
          wval = a + simm;
        end
        cpu_types_pkg::SLTI: begin
          wr   = 1'b1;
          wval = {31'd0, $signed(a) < $signed(simm)};
        end
        cpu_types_pkg::ANDI: begin
          wr   = 1'b1;
          wval = a & zimm;
        end
        cpu_types_pkg::ORI: begin
          wr   = 1'b1;
          wval = a | zimm;
        end
        cpu_types_pkg::XORI: begin
          wr   = 1'b1;
          wval = a ^ zimm;
        end
        cpu_types_pkg::LUI: begin
          wr   = 1'b1;
          wval = {ir[15:0], 16'h0000};
        end
        cpu_types_pkg::LW: begin
          wr   = 1'b1;
          wval = exp_mem[word_index(a + simm)];
        end
        cpu_types_pkg::SW: exp_mem[word_index(a + simm)] = b;
        cpu_types_pkg::BEQ: begin
          if (a == b) begin
            npc = pc + 32'd4 + (simm << 2);
          end
        end
        cpu_types_pkg::BNE: begin
          if (a != b) begin
            npc = pc + 32'd4 + (simm << 2);
          end
        end
        cpu_types_pkg::J: npc = {npc[31:28], ir[25:0], 2'b00};
        cpu_types_pkg::JAL: begin
          wr   = 1'b1;
          wreg = 5'd31;
          wval = pc + 32'd4;
          npc  = {npc[31:28], ir[25:0], 2'b00};
        end
        default: wr = 1'b0;
      endcase
      if (wr && (wreg != 5'd0)) begin
        ref_regs[wreg] = wval;
      end
      pc = npc;
    end
    return -1;
  endfunction

  task automatic check_value(input string name, input cpu_types_pkg::word_t expected,
                             input cpu_types_pkg::word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  initial begin
    cpu_types_pkg::word_t addr;
    int                   retired;
    int                   cycles;
    rst_n     = 1'b0;
    dump_addr = '0;

    retired = run_reference();
    if (retired < 0) begin
      errors++;
      $display("error: reference model never reached the halt word");
    end

    repeat (3) @(posedge CLK);
    rst_n <= 1'b1;
    @(posedge CLK);
    check_value("halt after reset", 32'd0, {31'd0, halt});

    // wait for halt, bounded by a cycle count
    for (cycles = 0; (cycles < HALT_TIMEOUT) && !halt; cycles++) begin
      @(posedge CLK);
    end

    if (!halt) begin
      errors++;
      $display("error: processor never halted within %0d cycles", HALT_TIMEOUT);
    end else begin
      // walk the data region through the dump port
      for (int i = 0; i < DATA_WORDS; i++) begin
        addr = DATA_BASE + 32'(4 * i);
        dump_addr <= addr;
        @(posedge CLK);
        check_value($sformatf("mem[%h]", addr), exp_mem[word_index(addr)], dump_data);
      end
      check_value("halt held", 32'd1, {31'd0, halt});
    end

    $display("checks: %0d  errors: %0d  retired by model: %0d", checks, errors, retired);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter cpu_types_pkg::word_t PC_INIT   = 32'h0000_0000,
  parameter int                   RAM_LAT   = 2,
  parameter int                   MEM_WORDS = 1024
) (
  input  logic                 CLK,
  input  logic                 rst_n,
  output logic                 halt,
  input  cpu_types_pkg::word_t dump_addr,
  output cpu_types_pkg::word_t dump_data
);

  cpu_types_pkg::dp_req_t dp_req;
  cpu_types_pkg::dp_rsp_t dp_rsp;
  cpu_types_pkg::word_t   ram_addr;
  cpu_types_pkg::word_t   ram_wdata;
  cpu_types_pkg::word_t   ram_rdata;
  logic                   ram_ren;
  logic                   ram_wen;
  logic                   ram_ready;

  datapath #(
    .PC_INIT (PC_INIT)
  ) u_datapath (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .dp_rsp (dp_rsp),
    .dp_req (dp_req),
    .halt   (halt)
  );

  memory_control u_memory_control (
    .dp_req    (dp_req),
    .dp_rsp    (dp_rsp),
    .ram_ren   (ram_ren),
    .ram_wen   (ram_wen),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata),
    .ram_ready (ram_ready)
  );

  ram #(
    .RAM_LAT   (RAM_LAT),
    .MEM_WORDS (MEM_WORDS)
  ) u_ram (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .ren       (ram_ren),
    .wen       (ram_wen),
    .addr      (ram_addr),
    .wdata     (ram_wdata),
    .rdata     (ram_rdata),
    .ready     (ram_ready),
    .dump_addr (dump_addr),
    .dump_data (dump_data)
  );

endmodule

`default_nettype wire

// File: ram.sv
`timescale 1ns/1ps
`default_nettype none

module ram #(
  parameter int RAM_LAT   = 2,
  parameter int MEM_WORDS = 1024
) (
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 ren,
  input  logic                 wen,
  input  cpu_types_pkg::word_t addr,
  input  cpu_types_pkg::word_t wdata,
  output cpu_types_pkg::word_t rdata,
  output logic                 ready,
  input  cpu_types_pkg::word_t dump_addr,
  output cpu_types_pkg::word_t dump_data
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int LAT_W = (RAM_LAT > 1) ? $clog2(RAM_LAT) : 1;

  cpu_types_pkg::word_t mem [MEM_WORDS];

  logic [IDX_W-1:0] word_idx;
  logic [IDX_W-1:0] dump_idx;
  logic [LAT_W-1:0] cnt_q;
  logic [LAT_W-1:0] cnt;
  logic [33:0]      req_q;
  logic             restart;
  logic             active;

  initial begin
    $readmemh("program.hex", mem);
  end

  assign word_idx = addr[IDX_W+1:2];
  assign dump_idx = dump_addr[IDX_W+1:2];
  assign active   = ren || wen;

  // a new request starts the count again
  assign restart = ({ren, wen, addr} != req_q);
  assign cnt     = restart ? '0 : cnt_q;
  assign ready   = active && (cnt == LAT_W'(RAM_LAT - 1));

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      req_q  <= '0;
      cnt_q  <= '0;
    end else begin
      req_q  <= {ren, wen, addr};
      if (ready || !active) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (wen && ready) begin
      mem[word_idx] <= wdata;
    end
  end

  assign rdata     = mem[word_idx];
  assign dump_data = mem[dump_idx];

endmodule

`default_nettype wire

// File: memory_control.sv
`timescale 1ns/1ps
`default_nettype none

module memory_control (
  input  cpu_types_pkg::dp_req_t dp_req,
  output cpu_types_pkg::dp_rsp_t dp_rsp,
  output logic                   ram_ren,
  output logic                   ram_wen,
  output cpu_types_pkg::word_t   ram_addr,
  output cpu_types_pkg::word_t   ram_wdata,
  input  cpu_types_pkg::word_t   ram_rdata,
  input  logic                   ram_ready
);

  logic data_sel;

  // data access wins the single port over fetch
  assign data_sel = dp_req.dmemren || dp_req.dmemwen;

  assign ram_ren   = data_sel ? dp_req.dmemren : dp_req.imemren;
  assign ram_wen   = data_sel && dp_req.dmemwen;
  assign ram_addr  = data_sel ? dp_req.dmemaddr : dp_req.imemaddr;
  assign ram_wdata = dp_req.dmemstore;

  always_comb begin
    dp_rsp.ihit     = !data_sel && dp_req.imemren && ram_ready;
    dp_rsp.imemload = ram_rdata;
    dp_rsp.dhit     = data_sel && ram_ready;
    dp_rsp.dmemload = ram_rdata;
  end

endmodule

`default_nettype wire

// File: datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = 32'h0000_0000
) (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  cpu_types_pkg::dp_rsp_t dp_rsp,
  output cpu_types_pkg::dp_req_t dp_req,
  output logic                   halt
);

  cpu_types_pkg::instr_u   instr;
  cpu_types_pkg::instr_u   instr_q;
  cpu_types_pkg::ctrl_t    ctrl;
  cpu_types_pkg::pcsrc_t   pcsrc;
  cpu_types_pkg::regbits_t wsel;
  cpu_types_pkg::word_t    wdat;
  cpu_types_pkg::word_t    rdat1;
  cpu_types_pkg::word_t    rdat2;
  cpu_types_pkg::word_t    imm_ext;
  cpu_types_pkg::word_t    alu_a;
  cpu_types_pkg::word_t    alu_b;
  cpu_types_pkg::word_t    alu_result;
  cpu_types_pkg::word_t    pc;
  cpu_types_pkg::word_t    pc_plus4;
  logic                    alu_zero;
  logic                    imemren;
  logic                    dmemren;
  logic                    dmemwen;
  logic                    mem_busy;
  logic                    done;
  logic                    branch_taken;

  // the ram port serves data while a load or store is out,
  // so the fetched word is held until the data hit
  assign mem_busy = dmemren || dmemwen;

  always_ff @(posedge CLK) begin
    if (dp_rsp.ihit) begin
      instr_q <= dp_rsp.imemload;
    end
  end

  assign instr = mem_busy ? instr_q : dp_rsp.imemload;

  control_unit u_control_unit (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // instruction complete: data hit for memory ops, fetch hit otherwise
  assign done = mem_busy ? dp_rsp.dhit : (dp_rsp.ihit && !ctrl.dren && !ctrl.dwen);

  assign wsel = ctrl.link       ? 5'd31 :
                ctrl.reg_dst_rd ? instr.r.rd : instr.r.rt;

  always_comb begin
    if (ctrl.mem_to_reg) begin
      wdat = dp_rsp.dmemload;
    end else if (ctrl.link) begin
      wdat = pc_plus4;
    end else begin
      wdat = alu_result;
    end
  end

  register_file u_register_file (
    .CLK   (CLK),
    .rst_n (rst_n),
    .wen   (done && ctrl.reg_wr),
    .wsel  (wsel),
    .rsel1 (instr.r.rs),
    .rsel2 (instr.r.rt),
    .wdat  (wdat),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  assign imm_ext = ctrl.ext_signed ? {{16{instr.i.imm16[15]}}, instr.i.imm16}
                                   : {16'h0000, instr.i.imm16};

  // shifts take rt on port a and the shift amount on port b
  assign alu_a = ctrl.alu_src_shamt ? rdat2 : rdat1;

  always_comb begin
    if (ctrl.alu_src_shamt) begin
      alu_b = {27'd0, instr.r.shamt};
    end else if (ctrl.alu_src_imm) begin
      alu_b = imm_ext;
    end else begin
      alu_b = rdat2;
    end
  end

  alu u_alu (
    .alu_op   (ctrl.alu_op),
    .port_a   (alu_a),
    .port_b   (alu_b),
    .result   (alu_result),
    .zero     (alu_zero),
    .negative (),
    .overflow ()
  );

  assign branch_taken = alu_zero ^ ctrl.branch_ne;

  always_comb begin
    pcsrc = ctrl.pcsrc;
    if ((ctrl.pcsrc == cpu_types_pkg::PC_BRANCH) && !branch_taken) begin
      pcsrc = cpu_types_pkg::PC_SEQ;
    end
  end

  program_counter #(
    .PC_INIT (PC_INIT)
  ) u_program_counter (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .pc_en    (done && !ctrl.halt),
    .pcsrc    (pcsrc),
    .imm16    (instr.i.imm16),
    .addr26   (instr.j.addr26),
    .rdat1    (rdat1),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  request_unit u_request_unit (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .ihit      (dp_rsp.ihit),
    .dhit      (dp_rsp.dhit),
    .ctrl_dren (ctrl.dren),
    .ctrl_dwen (ctrl.dwen),
    .halt      (halt),
    .imemren   (imemren),
    .dmemren   (dmemren),
    .dmemwen   (dmemwen)
  );

  // halt latch, set once and held until reset
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      halt <= 1'b0;
    end else if (dp_rsp.ihit && !mem_busy && ctrl.halt) begin
      halt <= 1'b1;
    end
  end

  always_comb begin
    dp_req.imemren   = imemren;
    dp_req.imemaddr  = pc;
    dp_req.dmemren   = dmemren;
    dp_req.dmemwen   = dmemwen;
    dp_req.dmemaddr  = alu_result;
    dp_req.dmemstore = rdat2;
  end

endmodule

`default_nettype wire

// File: request_unit.sv
`timescale 1ns/1ps
`default_nettype none

module request_unit (
  input  logic CLK,
  input  logic rst_n,
  input  logic ihit,
  input  logic dhit,
  input  logic ctrl_dren,
  input  logic ctrl_dwen,
  input  logic halt,
  output logic imemren,
  output logic dmemren,
  output logic dmemwen
);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      dmemren <= 1'b0;
      dmemwen <= 1'b0;
    end else if (dhit) begin
      dmemren <= 1'b0;
      dmemwen <= 1'b0;
    end else if (ihit) begin
      // data access starts the cycle after the fetch hit
      dmemren <= ctrl_dren;
      dmemwen <= ctrl_dwen;
    end
  end

  // fetch stops for good once halted
  assign imemren = !halt;

endmodule

`default_nettype wire

// File: program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter #(
  parameter cpu_types_pkg::word_t PC_INIT = 32'h0000_0000
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  pc_en,
  input  cpu_types_pkg::pcsrc_t pcsrc,
  input  logic [15:0]           imm16,
  input  logic [25:0]           addr26,
  input  cpu_types_pkg::word_t  rdat1,
  output cpu_types_pkg::word_t  pc,
  output cpu_types_pkg::word_t  pc_plus4
);

  cpu_types_pkg::word_t branch_target;
  cpu_types_pkg::word_t jump_target;
  cpu_types_pkg::word_t pc_next;

  assign pc_plus4      = pc + 32'd4;
  // word offset, sign extended
  assign branch_target = pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
  assign jump_target   = {pc_plus4[31:28], addr26, 2'b00};

  always_comb begin
    case (pcsrc)
      cpu_types_pkg::PC_BRANCH: pc_next = branch_target;
      cpu_types_pkg::PC_JUMP:   pc_next = jump_target;
      cpu_types_pkg::PC_JR:     pc_next = rdat1;
      default:                  pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pc <= PC_INIT;
    end else if (pc_en) begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  input  cpu_types_pkg::word_t    wdat,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);

  cpu_types_pkg::word_t regs [32];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != '0)) begin
      // register 0 is never written, so it always reads zero
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_types_pkg::aluop_t alu_op,
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  output cpu_types_pkg::word_t  result,
  output logic                  zero,
  output logic                  negative,
  output logic                  overflow
);

  always_comb begin
    result   = '0;
    overflow = 1'b0;
    case (alu_op)
      cpu_types_pkg::ALU_SLL: result = port_a << port_b[4:0];
      cpu_types_pkg::ALU_SRL: result = port_a >> port_b[4:0];
      cpu_types_pkg::ALU_ADD: begin
        result   = port_a + port_b;
        // same-sign operands giving a result of the other sign
        overflow = (port_a[31] == port_b[31]) && (result[31] != port_a[31]);
      end
      cpu_types_pkg::ALU_SUB: begin
        result   = port_a - port_b;
        overflow = (port_a[31] != port_b[31]) && (result[31] != port_a[31]);
      end
      cpu_types_pkg::ALU_AND:  result = port_a & port_b;
      cpu_types_pkg::ALU_OR:   result = port_a | port_b;
      cpu_types_pkg::ALU_XOR:  result = port_a ^ port_b;
      cpu_types_pkg::ALU_NOR:  result = ~(port_a | port_b);
      cpu_types_pkg::ALU_SLT:  result = {31'd0, $signed(port_a) < $signed(port_b)};
      cpu_types_pkg::ALU_SLTU: result = {31'd0, port_a < port_b};
      cpu_types_pkg::ALU_LUI:  result = {port_b[15:0], 16'h0000};
      default: result = '0;
    endcase
  end

  assign zero     = (result == '0);
  assign negative = result[31];

endmodule

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  cpu_types_pkg::instr_u instr,
  output cpu_types_pkg::ctrl_t  ctrl
);

  always_comb begin
    // default is a no-op: no register, memory or pc side effects
    ctrl = '0;
    if (instr == cpu_types_pkg::HALT_WORD) begin
      ctrl.halt = 1'b1;
    end else begin
      case (instr.r.opcode)
        cpu_types_pkg::RTYPE: begin
          ctrl.reg_wr     = 1'b1;
          ctrl.reg_dst_rd = 1'b1;
          case (instr.r.funct)
            cpu_types_pkg::SLL: begin
              ctrl.alu_op        = cpu_types_pkg::ALU_SLL;
              ctrl.alu_src_shamt = 1'b1;
            end
            cpu_types_pkg::SRL: begin
              ctrl.alu_op        = cpu_types_pkg::ALU_SRL;
              ctrl.alu_src_shamt = 1'b1;
            end
            cpu_types_pkg::ADDU: ctrl.alu_op = cpu_types_pkg::ALU_ADD;
            cpu_types_pkg::SUBU: ctrl.alu_op = cpu_types_pkg::ALU_SUB;
            cpu_types_pkg::AND:  ctrl.alu_op = cpu_types_pkg::ALU_AND;
            cpu_types_pkg::OR:   ctrl.alu_op = cpu_types_pkg::ALU_OR;
            cpu_types_pkg::XOR:  ctrl.alu_op = cpu_types_pkg::ALU_XOR;
            cpu_types_pkg::NOR:  ctrl.alu_op = cpu_types_pkg::ALU_NOR;
            cpu_types_pkg::SLT:  ctrl.alu_op = cpu_types_pkg::ALU_SLT;
            cpu_types_pkg::SLTU: ctrl.alu_op = cpu_types_pkg::ALU_SLTU;
            cpu_types_pkg::JR: begin
              ctrl.reg_wr = 1'b0;
              ctrl.pcsrc  = cpu_types_pkg::PC_JR;
            end
            default: begin
              // unknown funct, nothing written
              ctrl.reg_wr     = 1'b0;
              ctrl.reg_dst_rd = 1'b0;
            end
          endcase
        end
        cpu_types_pkg::ADDIU: begin
          ctrl.alu_op      = cpu_types_pkg::ALU_ADD;
          ctrl.alu_src_imm = 1'b1;
          ctrl.ext_signed  = 1'b1;
          ctrl.reg_wr      = 1'b1;
        end
        cpu_types_pkg::SLTI: begin
          ctrl.alu_op      = cpu_types_pkg::ALU_SLT;
          ctrl.alu_src_imm = 1'b1;
          ctrl.ext_signed  = 1'b1;
          ctrl.reg_wr      = 1'b1;
        end
        cpu_types_pkg::ANDI: begin
          ctrl.alu_op      = cpu_types_pkg::ALU_AND;
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_wr      = 1'b1;
        end
        cpu_types_pkg::ORI: begin
          ctrl.alu_op      = cpu_types_pkg::ALU_OR;
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_wr      = 1'b1;
        end
        cpu_types_pkg::XORI: begin
          ctrl.alu_op      = cpu_types_pkg::ALU_XOR;
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_wr      = 1'b1;
        end
        cpu_types_pkg::LUI: begin
          ctrl.alu_op      = cpu_types_pkg::ALU_LUI;
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_wr      = 1'b1;
        end
        cpu_types_pkg::LW: begin
          ctrl.alu_op      = cpu_types_pkg::ALU_ADD;
          ctrl.alu_src_imm = 1'b1;
          ctrl.ext_signed  = 1'b1;
          ctrl.reg_wr      = 1'b1;
          ctrl.mem_to_reg  = 1'b1;
          ctrl.dren        = 1'b1;
        end
        cpu_types_pkg::SW: begin
          ctrl.alu_op      = cpu_types_pkg::ALU_ADD;
          ctrl.alu_src_imm = 1'b1;
          ctrl.ext_signed  = 1'b1;
          ctrl.dwen        = 1'b1;
        end
        cpu_types_pkg::BEQ, cpu_types_pkg::BNE: begin
          // compare by subtraction, zero flag decides
          ctrl.alu_op    = cpu_types_pkg::ALU_SUB;
          ctrl.pcsrc     = cpu_types_pkg::PC_BRANCH;
          ctrl.branch_ne = (instr.i.opcode == cpu_types_pkg::BNE);
        end
        cpu_types_pkg::J: ctrl.pcsrc = cpu_types_pkg::PC_JUMP;
        cpu_types_pkg::JAL: begin
          ctrl.pcsrc  = cpu_types_pkg::PC_JUMP;
          ctrl.link   = 1'b1;
          ctrl.reg_wr = 1'b1;
        end
        default: ctrl = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // halt instruction, all ones
  localparam word_t HALT_WORD = 32'hffff_ffff;

  // major opcodes of the supported subset
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    SLTI  = 6'h0a,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    XORI  = 6'h0e,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b
  } opcode_t;

  // r-type function codes
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    JR   = 6'h08,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2a,
    SLTU = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL,
    ALU_SRL,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_LUI
  } aluop_t;

  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    regbits_t rd;
    logic [4:0] shamt;
    funct_t   funct;
  } r_type_t;

  typedef struct packed {
    opcode_t     opcode;
    regbits_t    rs;
    regbits_t    rt;
    logic [15:0] imm16;
  } i_type_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr26;
  } j_type_t;

  // one fetched word, seen in each of the three formats
  typedef union packed {
    r_type_t r;
    i_type_t i;
    j_type_t j;
  } instr_u;

  typedef enum logic [1:0] {
    PC_SEQ,
    PC_BRANCH,
    PC_JUMP,
    PC_JR
  } pcsrc_t;

  typedef struct packed {
    aluop_t alu_op;
    logic   alu_src_imm;
    logic   alu_src_shamt;
    logic   ext_signed;
    logic   reg_wr;
    logic   reg_dst_rd;
    logic   link;
    logic   mem_to_reg;
    logic   dren;
    logic   dwen;
    logic   branch_ne;
    pcsrc_t pcsrc;
    logic   halt;
  } ctrl_t;

  // datapath to memory controller
  typedef struct packed {
    logic  imemren;
    word_t imemaddr;
    logic  dmemren;
    logic  dmemwen;
    word_t dmemaddr;
    word_t dmemstore;
  } dp_req_t;

  // memory controller back to datapath
  typedef struct packed {
    logic  ihit;
    word_t imemload;
    logic  dhit;
    word_t dmemload;
  } dp_rsp_t;

endpackage

`default_nettype wire
